// ==== wb_cdc_pkg.sv ====
// wishbone clock-domain bridge
// shared bus widths and types
`default_nettype none

package wb_cdc_pkg;

	// data word and byte lanes
	parameter int DATA_W = 32;
	parameter int SEL_W  = DATA_W / 8;

	// word address is the byte address without the two low bits
	parameter int ADDR_W = 30;

	// one request as it crosses the request FIFO
	typedef struct packed {
		// write enable
		logic              we;
		// word address
		logic [ADDR_W-1:0] addr;
		// byte selects
		logic [SEL_W-1:0]  sel;
		// write data
		logic [DATA_W-1:0] dat;
	} wb_rqst_t;

	// one response word
	// reads carry the memory word and writes carry zero
	typedef struct packed {
		logic [DATA_W-1:0] dat;
	} wb_rsp_t;

endpackage

`default_nettype wire

// ==== async_fifo.sv ====
// dual-clock FIFO
// gray-coded pointers, first-word fall-through
`timescale 1ns/1ps
`default_nettype none

module async_fifo #(
	parameter int WIDTH      = 32,
	parameter int RQST_DEPTH = 4
) (
	input  logic             rst_n_i,
	input  logic             wr_clk_i,
	input  logic             write_i,
	input  logic [WIDTH-1:0] data_i,
	output logic             full_o,
	input  logic             rd_clk_i,
	input  logic             read_i,
	output logic [WIDTH-1:0] data_o,
	output logic             empty_o
);

	localparam int AW = $clog2(RQST_DEPTH);
	// full when the two top gray bits differ and the rest match
	localparam logic [AW+1:0] FULL_WIDE = {2'b11, {AW{1'b0}}};
	localparam logic [AW:0]   FULL_XOR  = FULL_WIDE[AW+1:1];

	logic [WIDTH-1:0] mem [RQST_DEPTH];

	logic [1:0]  wr_rst_q;
	logic        wr_rst_n;
	logic        wr_push;
	logic [AW:0] wr_bin;
	logic [AW:0] wr_bin_nxt;
	logic [AW:0] wr_gray;
	logic [AW:0] rd_gray_m;
	logic [AW:0] rd_gray_s;

	logic [1:0]  rd_rst_q;
	logic        rd_rst_n;
	logic        rd_pop;
	logic [AW:0] rd_bin;
	logic [AW:0] rd_bin_nxt;
	logic [AW:0] rd_gray;
	logic [AW:0] wr_gray_m;
	logic [AW:0] wr_gray_s;

	function automatic logic [AW:0] bin2gray(input logic [AW:0] b);
		return b ^ (b >> 1);
	endfunction

	// write domain reset release
	always_ff @(posedge wr_clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			wr_rst_q <= 2'b00;
		end else begin
			wr_rst_q <= {wr_rst_q[0], 1'b1};
		end
	end
	assign wr_rst_n = wr_rst_q[1];

	assign wr_push    = write_i && !full_o;
	assign wr_bin_nxt = wr_bin + {{AW{1'b0}}, wr_push};

	always_ff @(posedge wr_clk_i or negedge wr_rst_n) begin
		if (!wr_rst_n) begin
			wr_bin    <= '0;
			wr_gray   <= '0;
			rd_gray_m <= '0;
			rd_gray_s <= '0;
		end else begin
			wr_bin    <= wr_bin_nxt;
			wr_gray   <= bin2gray(wr_bin_nxt);
			rd_gray_m <= rd_gray;
			rd_gray_s <= rd_gray_m;
		end
	end

	// stale read pointer only makes full early
	assign full_o = (wr_gray ^ rd_gray_s) == FULL_XOR;

	always_ff @(posedge wr_clk_i) begin
		if (wr_push) begin
			mem[wr_bin[AW-1:0]] <= data_i;
		end
	end

	// read domain reset release
	always_ff @(posedge rd_clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			rd_rst_q <= 2'b00;
		end else begin
			rd_rst_q <= {rd_rst_q[0], 1'b1};
		end
	end
	assign rd_rst_n = rd_rst_q[1];

	assign rd_pop     = read_i && !empty_o;
	assign rd_bin_nxt = rd_bin + {{AW{1'b0}}, rd_pop};

	always_ff @(posedge rd_clk_i or negedge rd_rst_n) begin
		if (!rd_rst_n) begin
			rd_bin    <= '0;
			rd_gray   <= '0;
			wr_gray_m <= '0;
			wr_gray_s <= '0;
		end else begin
			rd_bin    <= rd_bin_nxt;
			rd_gray   <= bin2gray(rd_bin_nxt);
			wr_gray_m <= wr_gray;
			wr_gray_s <= wr_gray_m;
		end
	end

	assign empty_o = rd_gray == wr_gray_s;
	// head word shown without a read
	assign data_o  = mem[rd_bin[AW-1:0]];

endmodule

`default_nettype wire

// ==== wb_cdc.sv ====
// wishbone clock-domain bridge
// requests to the slave clock, responses back
`timescale 1ns/1ps
`default_nettype none

module wb_cdc #(
	parameter int RQST_DEPTH = 4
) (
	input  logic                 rst_n_i,
	input  logic                 m_clk_i,
	input  logic                 s_clk_i,
	input  logic                 m_wb_cyc_i,
	input  logic                 m_wb_stb_i,
	input  wb_cdc_pkg::wb_rqst_t m_wb_rqst_i,
	output logic                 m_wb_bsy_o,
	output logic                 m_wb_ack_o,
	output wb_cdc_pkg::wb_rsp_t  m_wb_dat_o,
	output logic                 s_wb_cyc_o,
	output logic                 s_wb_stb_o,
	output wb_cdc_pkg::wb_rqst_t s_wb_rqst_o,
	input  logic                 s_wb_bsy_i,
	input  logic                 s_wb_ack_i,
	input  wb_cdc_pkg::wb_rsp_t  s_wb_dat_i
);
	import wb_cdc_pkg::*;

	localparam int RQST_W = $bits(wb_rqst_t);
	localparam int RSP_W  = $bits(wb_rsp_t);

	logic              rqst_push;
	logic              rqst_pop;
	logic              rqst_empty;
	logic [RQST_W-1:0] rqst_head;
	logic              rsp_empty;
	logic [RSP_W-1:0]  rsp_head;
	logic              cyc_meta;

	// a full FIFO is the master stall
	assign rqst_push = m_wb_cyc_i && m_wb_stb_i;
	assign rqst_pop  = !rqst_empty && !s_wb_bsy_i;

	async_fifo #(
		.WIDTH      (RQST_W),
		.RQST_DEPTH (RQST_DEPTH)
	) rqst (
		.rst_n_i  (rst_n_i),
		.wr_clk_i (m_clk_i),
		.write_i  (rqst_push),
		.data_i   (m_wb_rqst_i),
		.full_o   (m_wb_bsy_o),
		.rd_clk_i (s_clk_i),
		.read_i   (rqst_pop),
		.data_o   (rqst_head),
		.empty_o  (rqst_empty)
	);

	// master cyc into the slave clock
	always_ff @(posedge s_clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			cyc_meta   <= 1'b0;
			s_wb_cyc_o <= 1'b0;
		end else begin
			cyc_meta   <= m_wb_cyc_i;
			s_wb_cyc_o <= cyc_meta;
		end
	end

	// stb stays up while the slave stalls
	always_ff @(posedge s_clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			s_wb_stb_o <= 1'b0;
		end else if (rqst_pop) begin
			s_wb_stb_o <= 1'b1;
		end else if (!s_wb_bsy_i) begin
			s_wb_stb_o <= 1'b0;
		end
	end

	always_ff @(posedge s_clk_i) begin
		if (rqst_pop) begin
			s_wb_rqst_o <= rqst_head;
		end
	end

	// never fills since the master side drains it every cycle
	async_fifo #(
		.WIDTH      (RSP_W),
		.RQST_DEPTH (RQST_DEPTH)
	) rsp (
		.rst_n_i  (rst_n_i),
		.wr_clk_i (s_clk_i),
		.write_i  (s_wb_ack_i),
		.data_i   (s_wb_dat_i),
		.full_o   (),
		.rd_clk_i (m_clk_i),
		.read_i   (1'b1),
		.data_o   (rsp_head),
		.empty_o  (rsp_empty)
	);

	always_ff @(posedge m_clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			m_wb_ack_o <= 1'b0;
		end else begin
			m_wb_ack_o <= !rsp_empty;
		end
	end

	always_ff @(posedge m_clk_i) begin
		m_wb_dat_o <= rsp_head;
	end

endmodule

`default_nettype wire

// ==== wb_ram.sv ====
// wishbone RAM slave
// byte selects, two-cycle registered read
`timescale 1ns/1ps
`default_nettype none

module wb_ram #(
	parameter int RAM_AW = 8
) (
	input  logic                 rst_n_i,
	input  logic                 s_clk_i,
	input  logic                 s_wb_cyc_i,
	input  logic                 s_wb_stb_i,
	input  wb_cdc_pkg::wb_rqst_t s_wb_rqst_i,
	output logic                 s_wb_bsy_o,
	output logic                 s_wb_ack_o,
	output wb_cdc_pkg::wb_rsp_t  s_wb_dat_o
);
	import wb_cdc_pkg::*;

	logic [DATA_W-1:0] mem [2**RAM_AW];
	logic [RAM_AW-1:0] req_idx;
	logic [RAM_AW-1:0] rd_addr;
	logic              rd_pend;
	logic              accept;

	assign accept  = s_wb_cyc_i && s_wb_stb_i && !s_wb_bsy_o;
	// upper address bits ignored so the RAM aliases
	assign req_idx = s_wb_rqst_i.addr[RAM_AW-1:0];

	always_ff @(posedge s_clk_i) begin
		if (accept && s_wb_rqst_i.we) begin
			for (int i = 0; i < SEL_W; i++) begin
				if (s_wb_rqst_i.sel[i]) begin
					mem[req_idx][8*i +: 8] <= s_wb_rqst_i.dat[8*i +: 8];
				end
			end
		end
	end

	// read keeps busy high on both cycles up to and including the ack
	always_ff @(posedge s_clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			rd_pend    <= 1'b0;
			s_wb_bsy_o <= 1'b0;
			s_wb_ack_o <= 1'b0;
		end else begin
			rd_pend    <= accept && !s_wb_rqst_i.we;
			s_wb_bsy_o <= (accept && !s_wb_rqst_i.we) || rd_pend;
			s_wb_ack_o <= (accept && s_wb_rqst_i.we) || rd_pend;
		end
	end

	always_ff @(posedge s_clk_i) begin
		if (accept) begin
			rd_addr <= req_idx;
		end
		if (rd_pend) begin
			s_wb_dat_o.dat <= mem[rd_addr];
		end else if (accept) begin
			// write response is zero
			s_wb_dat_o.dat <= '0;
		end
	end

endmodule

`default_nettype wire

// ==== wb_cdc_top.sv ====
// bridge and RAM slave
`timescale 1ns/1ps
`default_nettype none

module wb_cdc_top #(
	parameter int RQST_DEPTH = 4,
	parameter int RAM_AW     = 8
) (
	input  logic                 rst_n_i,
	input  logic                 m_clk_i,
	input  logic                 s_clk_i,
	input  logic                 m_wb_cyc_i,
	input  logic                 m_wb_stb_i,
	input  wb_cdc_pkg::wb_rqst_t m_wb_rqst_i,
	output logic                 m_wb_bsy_o,
	output logic                 m_wb_ack_o,
	output wb_cdc_pkg::wb_rsp_t  m_wb_dat_o
);
	import wb_cdc_pkg::*;

	// slave clock domain bus
	logic     s_wb_cyc;
	logic     s_wb_stb;
	wb_rqst_t s_wb_rqst;
	logic     s_wb_bsy;
	logic     s_wb_ack;
	wb_rsp_t  s_wb_dat;

	wb_cdc #(
		.RQST_DEPTH (RQST_DEPTH)
	) u_cdc (
		.rst_n_i     (rst_n_i),
		.m_clk_i     (m_clk_i),
		.s_clk_i     (s_clk_i),
		.m_wb_cyc_i  (m_wb_cyc_i),
		.m_wb_stb_i  (m_wb_stb_i),
		.m_wb_rqst_i (m_wb_rqst_i),
		.m_wb_bsy_o  (m_wb_bsy_o),
		.m_wb_ack_o  (m_wb_ack_o),
		.m_wb_dat_o  (m_wb_dat_o),
		.s_wb_cyc_o  (s_wb_cyc),
		.s_wb_stb_o  (s_wb_stb),
		.s_wb_rqst_o (s_wb_rqst),
		.s_wb_bsy_i  (s_wb_bsy),
		.s_wb_ack_i  (s_wb_ack),
		.s_wb_dat_i  (s_wb_dat)
	);

	wb_ram #(
		.RAM_AW (RAM_AW)
	) u_ram (
		.rst_n_i     (rst_n_i),
		.s_clk_i     (s_clk_i),
		.s_wb_cyc_i  (s_wb_cyc),
		.s_wb_stb_i  (s_wb_stb),
		.s_wb_rqst_i (s_wb_rqst),
		.s_wb_bsy_o  (s_wb_bsy),
		.s_wb_ack_o  (s_wb_ack),
		.s_wb_dat_o  (s_wb_dat)
	);

endmodule

`default_nettype wire

// ==== tb_wb_cdc_top.sv ====
// testbench for the wishbone clock-domain bridge
`timescale 1ns/1ps
`default_nettype none

module tb_wb_cdc_top;
	import wb_cdc_pkg::*;

	localparam int RQST_DEPTH = 4;
	localparam int RAM_AW     = 8;
	localparam int WIN_WORDS  = 16;
	localparam int RAND_OPS   = 200;

	// one table entry whose flag keeps stb up into the next entry
	typedef struct packed {
		logic     b2b;
		wb_rqst_t rqst;
	} step_t;

	logic     rst_n_i;
	logic     m_clk_i;
	logic     s_clk_i;
	logic     m_wb_cyc_i;
	logic     m_wb_stb_i;
	wb_rqst_t m_wb_rqst_i;
	logic     m_wb_bsy_o;
	logic     m_wb_ack_o;
	wb_rsp_t  m_wb_dat_o;

	step_t             steps[$];
	string             step_names[$];
	logic [DATA_W-1:0] exp_dat[$];
	string             exp_name[$];
	logic [DATA_W-1:0] model_mem [2**RAM_AW];
	logic [31:0]       rng_state;
	int                cycle_limit;
	int                accept_count;
	int                ack_count;
	int                errors;
	int                ack_errors;
	logic              bsy_seen;

	wb_cdc_top #(
		.RQST_DEPTH (RQST_DEPTH),
		.RAM_AW     (RAM_AW)
	) uut (
		.rst_n_i     (rst_n_i),
		.m_clk_i     (m_clk_i),
		.s_clk_i     (s_clk_i),
		.m_wb_cyc_i  (m_wb_cyc_i),
		.m_wb_stb_i  (m_wb_stb_i),
		.m_wb_rqst_i (m_wb_rqst_i),
		.m_wb_bsy_o  (m_wb_bsy_o),
		.m_wb_ack_o  (m_wb_ack_o),
		.m_wb_dat_o  (m_wb_dat_o)
	);

	initial begin
		m_clk_i = 1'b0;
		forever #10 m_clk_i = ~m_clk_i;
	end

	initial begin
		s_clk_i = 1'b0;
		forever #17 s_clk_i = ~s_clk_i;
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	task automatic add_step(input string name, input logic we, input logic [ADDR_W-1:0] addr,
			input logic [SEL_W-1:0] sel, input logic [DATA_W-1:0] dat, input logic b2b);
		steps.push_back({b2b, we, addr, sel, dat});
		step_names.push_back(name);
	endtask

	task automatic load_table();
		add_step("wr_full", 1'b1, 30'h10, 4'b1111, 32'hdead_beef, 1'b0);
		add_step("rd_full", 1'b0, 30'h10, 4'b1111, 32'h0, 1'b0);
		add_step("wr_base", 1'b1, 30'h20, 4'b1111, 32'h1122_3344, 1'b0);
		add_step("wr_sel0001", 1'b1, 30'h20, 4'b0001, 32'haaaa_aa55, 1'b0);
		add_step("wr_sel0100", 1'b1, 30'h20, 4'b0100, 32'hbb66_bbbb, 1'b0);
		add_step("wr_sel1010", 1'b1, 30'h20, 4'b1010, 32'h77cc_88dd, 1'b0);
		add_step("rd_merge", 1'b0, 30'h20, 4'b1111, 32'h0, 1'b0);
		// both hit word 0x20 once the upper bits are dropped
		add_step("wr_alias", 1'b1, 30'h120, 4'b0010, 32'h0000_9900, 1'b0);
		add_step("rd_alias", 1'b0, 30'h2000_0020, 4'b1111, 32'h0, 1'b0);
		// burst longer than the FIFO with stb held throughout
		for (int i = 0; i < 8; i++) begin
			add_step($sformatf("burst_wr%0d", i), 1'b1, ADDR_W'(48 + i), 4'b1111,
				32'hb000_0000 + i, 1'b1);
		end
		for (int i = 0; i < 8; i++) begin
			add_step($sformatf("burst_rd%0d", i), 1'b0, ADDR_W'(48 + i), 4'b1111,
				32'h0, i != 7);
		end
	endtask

	task automatic check_quiet(input string where);
		if (m_wb_ack_o !== 1'b0) begin
			errors++;
			$display("ack is not low %s", where);
		end
		if (m_wb_bsy_o !== 1'b0) begin
			errors++;
			$display("bsy is not low %s", where);
		end
	endtask

	// expected response from the reference memory
	task automatic record_accept(input wb_rqst_t rq, input string name);
		logic [RAM_AW-1:0] idx;
		idx = rq.addr[RAM_AW-1:0];
		if (rq.we) begin
			for (int b = 0; b < SEL_W; b++) begin
				if (rq.sel[b]) begin
					model_mem[idx][8*b +: 8] = rq.dat[8*b +: 8];
				end
			end
			exp_dat.push_back('0);
		end else begin
			exp_dat.push_back(model_mem[idx]);
		end
		exp_name.push_back(name);
		accept_count++;
	endtask

	// starts and returns on a rising edge
	task automatic send_request(input wb_rqst_t rq, input logic b2b, input string name);
		logic taken;
		m_wb_stb_i  <= 1'b1;
		m_wb_rqst_i <= rq;
		taken = 1'b0;
		while (!taken) begin
			@(negedge m_clk_i);
			taken = !m_wb_bsy_o;
			@(posedge m_clk_i);
		end
		record_accept(rq, name);
		if (!b2b) begin
			wait_drain();
		end
	endtask

	task automatic wait_drain();
		m_wb_stb_i <= 1'b0;
		while (exp_dat.size() != 0) begin
			@(posedge m_clk_i);
		end
		if (ack_count != accept_count) begin
			errors++;
			$display("%0d acks seen for %0d accepted requests", ack_count, accept_count);
		end
	endtask

	task automatic watch_acks();
		logic [DATA_W-1:0] want;
		string             nm;
		forever begin
			@(negedge m_clk_i);
			if (m_wb_bsy_o === 1'b1) begin
				bsy_seen = 1'b1;
			end
			if (m_wb_ack_o === 1'b1) begin
				ack_count++;
				if (exp_dat.size() == 0) begin
					ack_errors++;
					$display("ack arrived with no request outstanding");
				end else begin
					want = exp_dat.pop_front();
					nm   = exp_name.pop_front();
					if (m_wb_dat_o.dat !== want) begin
						ack_errors++;
						$display("mismatch %s: expected %h, actual %h", nm, want,
							m_wb_dat_o.dat);
					end
				end
			end
		end
	endtask

	task automatic watch_timeout();
		int cycles;
		cycles = 0;
		while (cycles < cycle_limit) begin
			@(posedge m_clk_i);
			cycles++;
		end
		$display("timeout after %0d cycles with %0d acks outstanding", cycles, exp_dat.size());
		$display("FAIL: see errors above");
		$finish;
	endtask

	initial begin
		wb_rqst_t    rq;
		logic [31:0] r;
		rst_n_i      = 1'b0;
		m_wb_cyc_i   = 1'b0;
		m_wb_stb_i   = 1'b0;
		m_wb_rqst_i  = '0;
		rng_state    = 32'd2;
		accept_count = 0;
		ack_count    = 0;
		errors       = 0;
		ack_errors   = 0;
		bsy_seen     = 1'b0;
		load_table();
		cycle_limit = 400 * (steps.size() + WIN_WORDS + RAND_OPS);
		fork
			watch_acks();
			watch_timeout();
		join_none

		for (int i = 0; i < 8; i++) begin
			@(negedge m_clk_i);
			check_quiet("during reset");
		end
		@(posedge m_clk_i);
		rst_n_i <= 1'b1;
		// both FIFOs release reset a few cycles later
		for (int i = 0; i < 8; i++) begin
			@(negedge m_clk_i);
			check_quiet("after reset");
		end
		@(posedge m_clk_i);
		m_wb_cyc_i <= 1'b1;

		foreach (steps[i]) begin
			send_request(steps[i].rqst, steps[i].b2b, step_names[i]);
		end
		wait_drain();
		if (!bsy_seen) begin
			errors++;
			$display("bsy never rose during the back-to-back burst");
		end

		// fill the random window so every read has a known word
		for (int i = 0; i < WIN_WORDS; i++) begin
			rng_state = xorshift32(rng_state);
			rq = {1'b1, ADDR_W'(64 + i), 4'b1111, rng_state};
			send_request(rq, i != WIN_WORDS - 1, $sformatf("init%0d", i));
		end
		for (int i = 0; i < RAND_OPS; i++) begin
			rng_state = xorshift32(rng_state);
			r = rng_state;
			rng_state = xorshift32(rng_state);
			// upper bits alias onto the window
			rq = {r[4], r[31:10], 4'h4, r[3:0], r[8:5], rng_state};
			send_request(rq, r[9], $sformatf("rand%0d", i));
		end
		wait_drain();
		repeat (20) @(posedge m_clk_i);
		wait_drain();
		m_wb_cyc_i <= 1'b0;
		@(posedge m_clk_i);

		$display("requests %0d, acks %0d, check errors %0d, ack errors %0d",
			accept_count, ack_count, errors, ack_errors);
		if (errors + ack_errors == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== flist.f ====
wb_cdc_pkg.sv
async_fifo.sv
wb_cdc.sv
wb_ram.sv
wb_cdc_top.sv
tb_wb_cdc_top.sv

// ==== Makefile ====
TOP = tb_wb_cdc_top

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --timescale 1ns/1ps --top-module $(TOP) -f flist.f

run: compile
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^PASS: all tests$$"

clean:
	rm -rf obj_dir
